/* logic/mem_pkg.sv */
// Shared memory definitions
`default_nettype none

package mem_pkg;

	// --------------------
	// Memory geometry
	// --------------------

	// Word address into the register memory
	typedef logic [3:0] mem_addr_t;

	// One memory word
	typedef logic [15:0] mem_data_t;

	// Number of words, one per address
	localparam int MEM_DEPTH = 16;

	// --------------------
	// Service timing
	// --------------------

	// Busy cycles before an access completes
	localparam int ACCESS_CYCLES = 3;

	// Timer count, wide enough for ACCESS_CYCLES-1
	typedef logic [1:0] access_count_t;

endpackage

`default_nettype wire

/* logic/fabric_pkg.sv */
// Client fabric definitions
`default_nettype none

package fabric_pkg;

	// --------------------
	// Client count
	// --------------------

	// Clients sharing the memory
	localparam int NUM_CLIENTS = 4;

	// Id width follows the client count
	localparam int CLIENT_ID_W = $clog2(NUM_CLIENTS);

	// One bit per client: requests, grants, one-hot winner
	typedef logic [NUM_CLIENTS-1:0] client_mask_t;

	// Encoded client number
	typedef logic [CLIENT_ID_W-1:0] client_id_t;

	// --------------------
	// Request and response
	// --------------------

	// Command held by a client until granted, 21 bits
	typedef struct packed {
		logic              write;
		mem_pkg::mem_addr_t addr;
		mem_pkg::mem_data_t wdata;
	} client_cmd_t;

	// Response tagged with the owner id, 19 bits
	typedef struct packed {
		client_id_t         id;
		logic               write;
		mem_pkg::mem_data_t rdata;
	} client_rsp_t;

endpackage

`default_nettype wire

/* logic/arbiter.sv */
// Round-robin client arbiter
`timescale 1ns/1ps
`default_nettype none

module arbiter (
	input  logic                     clk,
	input  logic                     rst_n,
	input  logic                     arb_en,
	input  fabric_pkg::client_mask_t req,
	input  fabric_pkg::client_cmd_t  cmd [fabric_pkg::NUM_CLIENTS],
	output logic                     win_valid,
	output fabric_pkg::client_mask_t winner,
	output fabric_pkg::client_id_t   win_id,
	output fabric_pkg::client_cmd_t  win_cmd
);

	// Encoded last winner, client 0 after reset
	fabric_pkg::client_id_t   last_id;
	// Clients strictly above the last winner
	fabric_pkg::client_mask_t upper_mask;
	fabric_pkg::client_mask_t upper_req;
	fabric_pkg::client_mask_t first_upper;
	fabric_pkg::client_mask_t first_any;
	fabric_pkg::client_mask_t pick;

	// Lowest set bit as a one-hot vector
	function automatic fabric_pkg::client_mask_t first_one(input fabric_pkg::client_mask_t vec);
		fabric_pkg::client_mask_t onehot;
		logic found;
		onehot = '0;
		found  = 1'b0;
		for (int i = 0; i < fabric_pkg::NUM_CLIENTS; i++) begin
			if (vec[i] && !found) begin
				onehot[i] = 1'b1;
				found     = 1'b1;
			end
		end
		return onehot;
	endfunction

	// --------------------
	// Winner selection
	// --------------------

	// Mask off last winner and everything below it
	always_comb begin
		upper_mask = '0;
		for (int i = 0; i < fabric_pkg::NUM_CLIENTS; i++) begin
			upper_mask[i] = (i > int'(last_id));
		end
	end

	assign upper_req   = req & upper_mask;
	assign first_upper = first_one(upper_req);
	assign first_any   = first_one(req);

	// Wrap to lowest requester when nothing above
	assign pick      = (|first_upper) ? first_upper : first_any;
	assign winner    = arb_en ? pick : '0;
	assign win_valid = |winner;

	// One-hot to encoded id
	always_comb begin
		win_id = '0;
		for (int i = 0; i < fabric_pkg::NUM_CLIENTS; i++) begin
			if (winner[i]) begin
				win_id = fabric_pkg::client_id_t'(i);
			end
		end
	end

	// Command mux
	always_comb begin
		win_cmd = '0;
		for (int i = 0; i < fabric_pkg::NUM_CLIENTS; i++) begin
			if (winner[i]) begin
				win_cmd = cmd[i];
			end
		end
	end

	// --------------------
	// Round-robin state
	// --------------------

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			last_id <= '0;
		end else if (win_valid) begin
			last_id <= win_id;
		end
	end

endmodule

`default_nettype wire

/* logic/access_fsm.sv */
// Access control state machine
`timescale 1ns/1ps
`default_nettype none

module access_fsm (
	input  logic                     clk,
	input  logic                     rst_n,
	input  fabric_pkg::client_mask_t req,
	input  logic                     win_valid,
	input  logic                     timer_done,
	output logic                     arb_en,
	output logic                     timer_start,
	output logic                     capture,
	output logic                     complete
);

	// Idle waits for requests, serve holds the memory busy
	typedef enum logic {
		IDLE,
		SERVE
	} fsm_state_t;

	fsm_state_t state;
	fsm_state_t state_next;

	// --------------------
	// Next state
	// --------------------

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				// Winner picked, memory goes busy
				if (win_valid) begin
					state_next = SERVE;
				end
			end
			SERVE: begin
				if (timer_done) begin
					state_next = IDLE;
				end
			end
			default: state_next = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	// --------------------
	// Outputs
	// --------------------

	// Arbitrate only while idle and someone asks
	assign arb_en      = (state == IDLE) && (|req);
	// Timer load and winner capture on the grant edge
	assign timer_start = (state == IDLE) && win_valid;
	assign capture     = (state == IDLE) && win_valid;
	// End of service
	assign complete    = (state == SERVE) && timer_done;

endmodule

`default_nettype wire

/* logic/access_timer.sv */
// Service time counter
`timescale 1ns/1ps
`default_nettype none

module access_timer (
	input  logic clk,
	input  logic rst_n,
	input  logic start,
	output logic done
);

	// Remaining cycles and running flag
	mem_pkg::access_count_t count;
	logic busy;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			count <= '0;
			busy  <= 1'b0;
		end else if (start) begin
			// Reload for a new access
			count <= mem_pkg::access_count_t'(mem_pkg::ACCESS_CYCLES - 1);
			busy  <= 1'b1;
		end else if (busy) begin
			if (count == '0) begin
				busy <= 1'b0;
			end else begin
				count <= count - 1'b1;
			end
		end
	end

	// Single pulse at zero while running
	assign done = busy && (count == '0);

endmodule

`default_nettype wire

/* logic/shared_mem.sv */
// Shared register memory
`timescale 1ns/1ps
`default_nettype none

module shared_mem (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    capture,
	input  logic                    complete,
	input  fabric_pkg::client_id_t  win_id,
	input  fabric_pkg::client_cmd_t win_cmd,
	output logic                    rsp_valid,
	output fabric_pkg::client_rsp_t rsp
);

	// Register storage
	mem_pkg::mem_data_t mem [mem_pkg::MEM_DEPTH];

	// Command in service
	fabric_pkg::client_id_t  cur_id;
	fabric_pkg::client_cmd_t cur_cmd;

	// --------------------
	// Capture
	// --------------------

	always_ff @(posedge clk) begin
		if (capture) begin
			cur_id  <= win_id;
			cur_cmd <= win_cmd;
		end
	end

	// --------------------
	// Access
	// --------------------

	// Memory reads zero out of reset
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < mem_pkg::MEM_DEPTH; i++) begin
				mem[i] <= '0;
			end
		end else if (complete && cur_cmd.write) begin
			mem[cur_cmd.addr] <= cur_cmd.wdata;
		end
	end

	// Response one cycle after completion
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rsp_valid <= 1'b0;
		end else begin
			rsp_valid <= complete;
		end
	end

	always_ff @(posedge clk) begin
		if (complete) begin
			rsp.id    <= cur_id;
			rsp.write <= cur_cmd.write;
			// writes return no data
			rsp.rdata <= cur_cmd.write ? '0 : mem[cur_cmd.addr];
		end
	end

endmodule

`default_nettype wire

/* logic/fabric_top.sv */
// Shared memory access fabric
`timescale 1ns/1ps
`default_nettype none

module fabric_top (
	input  logic                     clk,
	input  logic                     rst_n,
	input  fabric_pkg::client_mask_t req,
	input  fabric_pkg::client_cmd_t  cmd [fabric_pkg::NUM_CLIENTS],
	output fabric_pkg::client_mask_t grant,
	output logic                     rsp_valid,
	output fabric_pkg::client_rsp_t  rsp
);

	// --------------------
	// Internal nets
	// --------------------

	// FSM to arbiter
	logic arb_en;
	// Arbiter result
	logic                    win_valid;
	fabric_pkg::client_id_t  win_id;
	fabric_pkg::client_cmd_t win_cmd;
	// Timer handshake
	logic timer_start;
	logic timer_done;
	// Memory control
	logic capture;
	logic complete;

	// --------------------
	// Instances
	// --------------------

	// One-hot winner is the client grant
	arbiter arbiter_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.arb_en    (arb_en),
		.req       (req),
		.cmd       (cmd),
		.win_valid (win_valid),
		.winner    (grant),
		.win_id    (win_id),
		.win_cmd   (win_cmd)
	);

	access_fsm access_fsm_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.req         (req),
		.win_valid   (win_valid),
		.timer_done  (timer_done),
		.arb_en      (arb_en),
		.timer_start (timer_start),
		.capture     (capture),
		.complete    (complete)
	);

	access_timer access_timer_inst (
		.clk   (clk),
		.rst_n (rst_n),
		.start (timer_start),
		.done  (timer_done)
	);

	shared_mem shared_mem_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.capture   (capture),
		.complete  (complete),
		.win_id    (win_id),
		.win_cmd   (win_cmd),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

endmodule

`default_nettype wire

/* tests/fabric_checker.sv */
// Grant and response timing checks
`timescale 1ns/1ps
`default_nettype none

module fabric_checker (
	input logic                     clk,
	input logic                     rst_n,
	input fabric_pkg::client_mask_t grant,
	input logic                     rsp_valid
);

	// Grant to response distance
	localparam int RSP_DELAY = mem_pkg::ACCESS_CYCLES + 1;

	// --------------------
	// Grant shape
	// --------------------

	grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(grant))
		else $error("grant has more than one bit set");

	// Memory busy until the response cycle
	grant_while_busy: assert property (@(posedge clk) disable iff (!rst_n)
		(|grant) |-> ##1 (grant == '0) ##1 (grant == '0) ##1 (grant == '0))
		else $error("grant issued while a response is pending");

	// --------------------
	// Response timing
	// --------------------

	rsp_single: assert property (@(posedge clk) disable iff (!rst_n)
		rsp_valid |=> !rsp_valid)
		else $error("rsp_valid high two cycles in a row");

	rsp_latency: assert property (@(posedge clk) disable iff (!rst_n)
		(|grant) |-> ##RSP_DELAY rsp_valid)
		else $error("no response at the expected cycle after a grant");

endmodule

bind fabric_top fabric_checker fabric_checker_inst (
	.clk       (clk),
	.rst_n     (rst_n),
	.grant     (grant),
	.rsp_valid (rsp_valid)
);

`default_nettype wire

/* tests/fabric_tb.sv */
// Access fabric testbench
`timescale 1ns/1ps
`default_nettype none

module fabric_tb;

	// --------------------
	// Stimulus table
	// --------------------

	localparam int NUM_ROWS = 8;
	localparam int CYCLE_LIMIT =
		NUM_ROWS * fabric_pkg::NUM_CLIENTS * (mem_pkg::ACCESS_CYCLES + 2) + 50;

	// One row: requesting clients, random write data flag, a command per client
	typedef struct packed {
		fabric_pkg::client_mask_t                                 req;
		logic                                                     rand_data;
		fabric_pkg::client_cmd_t [fabric_pkg::NUM_CLIENTS-1:0] cmds;
	} row_t;

	row_t rows [NUM_ROWS];

	// DUT signals
	logic                     clk = 1'b0;
	logic                     rst_n;
	fabric_pkg::client_mask_t req;
	fabric_pkg::client_cmd_t  cmd [fabric_pkg::NUM_CLIENTS];
	fabric_pkg::client_mask_t grant;
	logic                     rsp_valid;
	fabric_pkg::client_rsp_t  rsp;

	// Reference model state
	fabric_pkg::client_id_t   ref_last;
	mem_pkg::mem_data_t       ref_mem [mem_pkg::MEM_DEPTH];
	fabric_pkg::client_rsp_t  exp_rsp;
	fabric_pkg::client_mask_t pending;
	fabric_pkg::client_cmd_t  cur_cmd [fabric_pkg::NUM_CLIENTS];
	int                       rsp_wait;
	int                       cycles = 0;
	integer                   seed;

	fabric_top fabric_top_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.cmd       (cmd),
		.grant     (grant),
		.rsp_valid (rsp_valid),
		.rsp       (rsp)
	);

	// 100 ns period
	always #50 clk = ~clk;

	// Run length guard
	always @(posedge clk) begin
		if (rst_n) begin
			cycles <= cycles + 1;
			if (cycles > CYCLE_LIMIT) begin
				$display("Timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
				$display("Finished with errors");
				$fatal(1, "cycle limit reached");
			end
		end
	end

	// --------------------
	// Compare tasks
	// --------------------

	task automatic check_grant(input fabric_pkg::client_mask_t act,
		input fabric_pkg::client_mask_t exp);
		if (act !== exp) begin
			$display("[FAIL] %0t: grant %b, expected %b", $time, act, exp);
			$display("Finished with errors");
			$fatal(1, "grant mismatch");
		end
	endtask

	// Payload only compared when a response is due
	task automatic check_rsp(input logic act_valid, input fabric_pkg::client_rsp_t act,
		input logic exp_valid, input fabric_pkg::client_rsp_t exp);
		if (act_valid !== exp_valid) begin
			$display("[FAIL] %0t: rsp_valid %b, expected %b", $time, act_valid, exp_valid);
			$display("Finished with errors");
			$fatal(1, "response strobe mismatch");
		end else if (exp_valid && (act !== exp)) begin
			$display("[FAIL] %0t: rsp id %0d write %b data %h, expected id %0d write %b data %h",
				$time, act.id, act.write, act.rdata, exp.id, exp.write, exp.rdata);
			$display("Finished with errors");
			$fatal(1, "response mismatch");
		end
	endtask

	// --------------------
	// Reference model
	// --------------------

	// Search upward from the client after the last winner, wrapping around
	function automatic fabric_pkg::client_id_t next_winner(input fabric_pkg::client_mask_t mask,
		input fabric_pkg::client_id_t last);
		fabric_pkg::client_id_t id;
		int idx;
		logic found;
		id    = '0;
		found = 1'b0;
		for (int k = 1; k <= fabric_pkg::NUM_CLIENTS; k++) begin
			idx = (int'(last) + k) % fabric_pkg::NUM_CLIENTS;
			if (mask[idx] && !found) begin
				id    = fabric_pkg::client_id_t'(idx);
				found = 1'b1;
			end
		end
		return id;
	endfunction

	function automatic fabric_pkg::client_cmd_t cmd_of(input logic write,
		input mem_pkg::mem_addr_t addr, input mem_pkg::mem_data_t wdata);
		fabric_pkg::client_cmd_t c;
		c.write = write;
		c.addr  = addr;
		c.wdata = wdata;
		return c;
	endfunction

	// One clock: drive after the edge, check at the falling edge
	task automatic run_cycle();
		fabric_pkg::client_mask_t exp_grant;
		fabric_pkg::client_id_t id;
		logic exp_valid;
		@(posedge clk);
		#1;
		req = pending;
		cmd = cur_cmd;
		@(negedge clk);
		// Response side first, a new grant may share its cycle
		exp_valid = 1'b0;
		if (rsp_wait > 0) begin
			rsp_wait--;
			exp_valid = (rsp_wait == 0);
		end
		check_rsp(rsp_valid, rsp, exp_valid, exp_rsp);
		exp_grant = '0;
		id        = '0;
		if ((rsp_wait == 0) && (pending != '0)) begin
			id        = next_winner(pending, ref_last);
			exp_grant = fabric_pkg::client_mask_t'(1) << id;
		end
		check_grant(grant, exp_grant);
		if (exp_grant != '0) begin
			// Serialized service, so the model can act at grant time
			exp_rsp.id    = id;
			exp_rsp.write = cur_cmd[id].write;
			if (cur_cmd[id].write) begin
				ref_mem[cur_cmd[id].addr] = cur_cmd[id].wdata;
				exp_rsp.rdata = '0;
			end else begin
				exp_rsp.rdata = ref_mem[cur_cmd[id].addr];
			end
			ref_last = id;
			pending  = pending & ~exp_grant;
			rsp_wait = mem_pkg::ACCESS_CYCLES + 1;
		end
	endtask

	// --------------------
	// Table contents
	// --------------------

	task automatic load_table();
		for (int r = 0; r < NUM_ROWS; r++) begin
			rows[r] = '0;
		end
		// Lone client 0 write, then its read back
		rows[0].req     = 4'b0001;
		rows[0].cmds[0] = cmd_of(1'b1, 4'd3, 16'hA5A5);
		rows[1].req     = 4'b0001;
		rows[1].cmds[0] = cmd_of(1'b0, 4'd3, 16'h0000);
		// All four write random words, rotation 1 2 3 0
		rows[2].req       = 4'b1111;
		rows[2].rand_data = 1'b1;
		rows[3].req       = 4'b1111;
		for (int c = 0; c < fabric_pkg::NUM_CLIENTS; c++) begin
			rows[2].cmds[c] = cmd_of(1'b1, mem_pkg::mem_addr_t'(4 + c), 16'h0000);
			rows[3].cmds[c] = cmd_of(1'b0, mem_pkg::mem_addr_t'(7 - c), 16'h0000);
		end
		// Client 2 wins alone, then the mask wraps to client 0
		rows[4].req     = 4'b0100;
		rows[4].cmds[2] = cmd_of(1'b1, 4'd9, 16'h1234);
		rows[5].req     = 4'b0101;
		rows[5].cmds[0] = cmd_of(1'b0, 4'd9, 16'h0000);
		rows[5].cmds[2] = cmd_of(1'b0, 4'd4, 16'h0000);
		// Read before a random overwrite of the same word
		rows[6].req       = 4'b1010;
		rows[6].rand_data = 1'b1;
		rows[6].cmds[1]   = cmd_of(1'b1, 4'd9, 16'h0000);
		rows[6].cmds[3]   = cmd_of(1'b0, 4'd9, 16'h0000);
		rows[7].req       = 4'b0110;
		rows[7].cmds[1]   = cmd_of(1'b0, 4'd0, 16'h0000);
		rows[7].cmds[2]   = cmd_of(1'b0, 4'd9, 16'h0000);
	endtask

	// --------------------
	// Main sequence
	// --------------------

	initial begin
		seed     = 4727;
		rst_n    = 1'b0;
		req      = '0;
		pending  = '0;
		rsp_wait = 0;
		ref_last = '0;
		exp_rsp  = '0;
		for (int c = 0; c < fabric_pkg::NUM_CLIENTS; c++) begin
			cmd[c]     = '0;
			cur_cmd[c] = '0;
		end
		for (int a = 0; a < mem_pkg::MEM_DEPTH; a++) begin
			ref_mem[a] = '0;
		end
		load_table();
		repeat (8) @(posedge clk);
		#1;
		rst_n = 1'b1;
		// Quiet fabric with no requests
		repeat (3) run_cycle();
		for (int r = 0; r < NUM_ROWS; r++) begin
			pending = rows[r].req;
			for (int c = 0; c < fabric_pkg::NUM_CLIENTS; c++) begin
				cur_cmd[c] = rows[r].cmds[c];
				if (rows[r].rand_data && cur_cmd[c].write) begin
					cur_cmd[c].wdata = mem_pkg::mem_data_t'($random(seed));
				end
			end
			// Every client granted and the last response seen
			while ((pending != '0) || (rsp_wait != 0)) begin
				run_cycle();
			end
		end
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
logic/mem_pkg.sv
logic/fabric_pkg.sv
logic/arbiter.sv
logic/access_fsm.sv
logic/access_timer.sv
logic/shared_mem.sv
logic/fabric_top.sv
tests/fabric_checker.sv
tests/fabric_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the fabric testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f build.log sim.log
verilator --binary --timing --assert --top-module fabric_tb -f filelist.f -o fabric_sim \
	> build.log 2>&1 || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/fabric_sim > sim.log 2>&1; cat sim.log
grep -q "Finished with no errors" sim.log && exit 0 || exit 1
